// File: source/fightPkg.sv
package fightPkg;

	// Screen coordinates, x in the upper half of the word
	typedef struct packed {
		logic [15:0] x;
		logic [15:0] y;
	} point;

	typedef struct packed {
		logic [15:0] width;
		logic [15:0] height;
	} extent;

	typedef struct packed {
		point pos;
		extent size;
	} box;

	// Controller word as sampled from the pad
	typedef struct packed {
		logic [4:0] spare27;
		logic facing;
		logic [1:0] spare24;
		logic smashLeft;
		logic smashRight;
		logic smashUp;
		logic smashDown;
		logic [1:0] spare18;
		logic bButton;
		logic aButton;
		logic [2:0] stickX;
		logic [4:0] spare8;
		logic [2:0] stickY;
		logic [4:0] spare0;
	} controlWord;

	typedef enum logic [3:0] {
		none,
		smashLeft,
		smashRight,
		smashUp,
		smashDown,
		jabLeft,
		jabRight,
		specialNeutralLeft,
		specialNeutralRight,
		specialLeft,
		specialRight,
		specialUp,
		specialDown
	} attackKind;

	// Which hitbox an attack swings through
	typedef enum logic [1:0] {
		left,
		right,
		up,
		down
	} direction;

	typedef struct packed {
		logic [19:0] zero;
		logic active;
		logic specialNeutral;
		logic specialRight;
		logic specialLeft;
		logic specialDown;
		logic specialUp;
		logic jab;
		logic smashRight;
		logic smashLeft;
		logic smashDown;
		logic smashUp;
		logic hit;
	} attackStatus;

	// Active cycles per attack
	localparam int jabDuration = 8;
	localparam int longDuration = 16;
	localparam int timerWidth = 5;

	// Knockback vectors, x in the upper half
	localparam logic [31:0] knockSmashUp = 32'h0000_0800;
	localparam logic [31:0] knockSmashDown = 32'h0000_F7FE;
	localparam logic [31:0] knockSmashLeft = 32'hF7FE_00E0;
	localparam logic [31:0] knockSmashRight = 32'h0800_00E0;
	localparam logic [31:0] knockJabLeft = 32'hFBFE_0080;
	localparam logic [31:0] knockJabRight = 32'h0400_0080;

	localparam logic [31:0] upSpecialMove = 32'h0000_0010;

endpackage

// File: source/inputDecoder.sv
`timescale 1ns/1ps

module inputDecoder (
	input fightPkg::controlWord controls,
	output fightPkg::attackKind request
);
	import fightPkg::*;

	logic tiltLeft;
	logic tiltRight;
	logic tiltUp;
	logic tiltDown;
	logic centred;

	// Stick tilts only count when pushed to the end of travel
	assign tiltLeft = (controls.stickX == 3'b000);
	assign tiltRight = (controls.stickX == 3'b111);
	assign tiltUp = (controls.stickY == 3'b111);
	assign tiltDown = (controls.stickY == 3'b000);
	assign centred = !tiltLeft && !tiltRight && !tiltUp && !tiltDown;

	// Smashes win over jabs, jabs over specials
	always_comb begin
		if (controls.smashLeft) begin
			request = smashLeft;
		end else if (controls.smashRight) begin
			request = smashRight;
		end else if (controls.smashUp) begin
			request = smashUp;
		end else if (controls.smashDown) begin
			request = smashDown;
		end else if (controls.aButton) begin
			request = controls.facing ? jabRight : jabLeft;
		end else if (controls.bButton && tiltLeft) begin
			request = specialLeft;
		end else if (controls.bButton && tiltRight) begin
			request = specialRight;
		end else if (controls.bButton && tiltUp) begin
			request = specialUp;
		end else if (controls.bButton && tiltDown) begin
			request = specialDown;
		end else if (controls.bButton && centred) begin
			// Neutral B swings the way the character faces
			request = controls.facing ? specialNeutralRight : specialNeutralLeft;
		end else begin
			request = none;
		end
	end

endmodule

// File: source/attackControl.sv
`timescale 1ns/1ps

module attackControl (
	input logic clock,
	input logic arstN,
	input fightPkg::attackKind request,
	output fightPkg::attackKind activeKind
);
	import fightPkg::*;

	logic [timerWidth-1:0] timer;
	logic lastCycle;

	function automatic logic [timerWidth-1:0] durationOf(attackKind kind);
		case (kind)
			jabLeft, jabRight: durationOf = timerWidth'(jabDuration);
			default: durationOf = timerWidth'(longDuration);
		endcase
	endfunction

	// Timer counts down to one on the final active cycle
	assign lastCycle = (timer == timerWidth'(1));

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			activeKind <= none;
			timer <= '0;
		end else if (activeKind == none) begin
			// Accepted only while idle and never queued
			if (request != none) begin
				activeKind <= request;
				timer <= durationOf(request);
			end
		end else if (lastCycle) begin
			activeKind <= none;
			timer <= '0;
		end else begin
			timer <= timer - timerWidth'(1);
		end
	end

	// Leaving idle always means taking the request seen while idle
	idleTakesRequest: assert property (
		@(posedge clock) disable iff (!arstN)
		(activeKind == none) |=> (activeKind == $past(request))
	);

	// No direct switch from one attack to another
	activeHoldsOrEnds: assert property (
		@(posedge clock) disable iff (!arstN)
		(activeKind != none) |=> (activeKind == $past(activeKind)) || (activeKind == none)
	);

	// Jabs last exactly jabDuration cycles
	jabLength: assert property (
		@(posedge clock) disable iff (!arstN)
		(activeKind == none) ##1 (activeKind inside {jabLeft, jabRight})
			|-> (activeKind != none) [*jabDuration] ##1 (activeKind == none)
	);

endmodule

// File: source/hitboxGenerator.sv
`timescale 1ns/1ps

module hitboxGenerator (
	input fightPkg::box attacker,
	output fightPkg::box hitLeft,
	output fightPkg::box hitRight,
	output fightPkg::box hitUp,
	output fightPkg::box hitDown
);
	import fightPkg::*;

	extent halfSize;
	logic [15:0] quarterWidth;
	logic [15:0] quarterHeight;

	// Every hitbox is half the attacker's size on each axis
	assign halfSize = '{
		width: attacker.size.width >> 1,
		height: attacker.size.height >> 1
	};
	assign quarterWidth = halfSize.width >> 1;
	assign quarterHeight = halfSize.height >> 1;

	// Beside the body, raised a quarter of its height
	assign hitLeft = '{
		pos: '{
			x: attacker.pos.x - halfSize.width,
			y: attacker.pos.y + quarterHeight
		},
		size: halfSize
	};

	assign hitRight = '{
		pos: '{
			x: attacker.pos.x + attacker.size.width,
			y: attacker.pos.y + quarterHeight
		},
		size: halfSize
	};

	// Above and below, inset a quarter of the width
	assign hitUp = '{
		pos: '{
			x: attacker.pos.x + quarterWidth,
			y: attacker.pos.y + attacker.size.height
		},
		size: halfSize
	};

	// Hangs a quarter height below the feet, overlapping the body
	assign hitDown = '{
		pos: '{
			x: attacker.pos.x + quarterWidth,
			y: attacker.pos.y - quarterHeight
		},
		size: halfSize
	};

endmodule

// File: source/boxOverlap.sv
`timescale 1ns/1ps

module boxOverlap (
	input fightPkg::box first,
	input fightPkg::box second,
	output logic overlap
);

	logic [15:0] firstEndX;
	logic [15:0] firstEndY;
	logic [15:0] secondEndX;
	logic [15:0] secondEndY;
	logic overlapX;
	logic overlapY;

	// Far edges, unsigned and allowed to wrap
	assign firstEndX = first.pos.x + first.size.width;
	assign firstEndY = first.pos.y + first.size.height;
	assign secondEndX = second.pos.x + second.size.width;
	assign secondEndY = second.pos.y + second.size.height;

	// Strict compare so boxes that only touch do not count
	assign overlapX = (first.pos.x < secondEndX) && (second.pos.x < firstEndX);
	assign overlapY = (first.pos.y < secondEndY) && (second.pos.y < firstEndY);

	assign overlap = overlapX && overlapY;

endmodule

// File: source/attackEffects.sv
`timescale 1ns/1ps

module attackEffects (
	input logic clock,
	input logic arstN,
	input fightPkg::attackKind activeKind,
	input logic overlapLeft,
	input logic overlapRight,
	input logic overlapUp,
	input logic overlapDown,
	output fightPkg::attackStatus attack,
	output logic [31:0] knockback,
	output logic [31:0] movement
);
	import fightPkg::*;

	direction hitDirection;
	logic directionOverlap;

	// Jabs and neutral specials already carry their facing in the kind
	function automatic direction kindDirection(attackKind kind);
		case (kind)
			smashRight, jabRight, specialNeutralRight, specialRight: kindDirection = right;
			smashUp, specialUp: kindDirection = up;
			smashDown, specialDown: kindDirection = down;
			default: kindDirection = left;
		endcase
	endfunction

	assign hitDirection = kindDirection(activeKind);

	always_comb begin
		case (hitDirection)
			left: directionOverlap = overlapLeft;
			right: directionOverlap = overlapRight;
			up: directionOverlap = overlapUp;
			default: directionOverlap = overlapDown;
		endcase
	end

	always_comb begin
		attack = '0;
		attack.active = (activeKind != none);
		attack.hit = attack.active && directionOverlap;
		attack.smashUp = (activeKind == smashUp);
		attack.smashDown = (activeKind == smashDown);
		attack.smashLeft = (activeKind == smashLeft);
		attack.smashRight = (activeKind == smashRight);
		attack.jab = (activeKind == jabLeft) || (activeKind == jabRight);
		attack.specialUp = (activeKind == specialUp);
		attack.specialDown = (activeKind == specialDown);
		attack.specialLeft = (activeKind == specialLeft);
		attack.specialRight = (activeKind == specialRight);
		attack.specialNeutral = (activeKind == specialNeutralLeft) ||
			(activeKind == specialNeutralRight);
	end

	// Knockback is applied whether or not the attack connects
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			knockback <= '0;
		end else begin
			case (activeKind)
				smashUp: knockback <= knockSmashUp;
				smashDown: knockback <= knockSmashDown;
				smashLeft: knockback <= knockSmashLeft;
				smashRight: knockback <= knockSmashRight;
				jabLeft: knockback <= knockJabLeft;
				jabRight: knockback <= knockJabRight;
				default: knockback <= knockback;
			endcase
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			movement <= '0;
		end else if (activeKind == specialUp) begin
			movement <= upSpecialMove;
		end
	end

	kindFlagsOneHot: assert property (
		@(posedge clock) disable iff (!arstN)
		$onehot0(attack[10:1])
	);

endmodule

// File: source/attackCoprocessor.sv
`timescale 1ns/1ps

module attackCoprocessor (
	input logic clock,
	input logic arstN,
	input fightPkg::point char1Pos,
	input fightPkg::extent char1Size,
	input fightPkg::point char2Pos,
	input fightPkg::extent char2Size,
	input fightPkg::controlWord controls,
	output fightPkg::attackStatus attack,
	output logic [31:0] knockback,
	output logic [31:0] movement
);
	import fightPkg::*;

	attackKind request;
	attackKind activeKind;
	box char1Box;
	box char2Box;
	box hitLeft;
	box hitRight;
	box hitUp;
	box hitDown;
	logic overlapLeft;
	logic overlapRight;
	logic overlapUp;
	logic overlapDown;

	assign char1Box = '{pos: char1Pos, size: char1Size};
	assign char2Box = '{pos: char2Pos, size: char2Size};

	inputDecoder decoder (
		.controls(controls),
		.request(request)
	);

	attackControl control (
		.clock(clock),
		.arstN(arstN),
		.request(request),
		.activeKind(activeKind)
	);

	hitboxGenerator hitboxes (
		.attacker(char1Box),
		.hitLeft(hitLeft),
		.hitRight(hitRight),
		.hitUp(hitUp),
		.hitDown(hitDown)
	);

	// One overlap test per direction against character 2
	boxOverlap leftTest (.first(hitLeft), .second(char2Box), .overlap(overlapLeft));
	boxOverlap rightTest (.first(hitRight), .second(char2Box), .overlap(overlapRight));
	boxOverlap upTest (.first(hitUp), .second(char2Box), .overlap(overlapUp));
	boxOverlap downTest (.first(hitDown), .second(char2Box), .overlap(overlapDown));

	attackEffects effects (
		.clock(clock),
		.arstN(arstN),
		.activeKind(activeKind),
		.overlapLeft(overlapLeft),
		.overlapRight(overlapRight),
		.overlapUp(overlapUp),
		.overlapDown(overlapDown),
		.attack(attack),
		.knockback(knockback),
		.movement(movement)
	);

endmodule

// File: tests/attackCoprocessorTb.sv
`timescale 1ns/1ps

module attackCoprocessorTb;
	import fightPkg::*;

	localparam int kindJabLeft = 5;
	localparam int kindJabRight = 6;
	localparam int kindSpecialUp = 11;
	// Setup cycle, up to 16 active cycles and the idle cycle plus slack
	localparam int cyclesPerRun = 20;
	localparam int runCount = 12 + 5 * 12 + 8 + 6 + 2 * 40;
	localparam int cycleBudget = runCount * cyclesPerRun + 50;

	logic clock;
	logic arstN;
	logic [31:0] char1Pos;
	logic [31:0] char1Size;
	logic [31:0] char2Pos;
	logic [31:0] char2Size;
	logic [31:0] controls;
	attackStatus attack;
	logic [31:0] knockback;
	logic [31:0] movement;

	logic [31:0] appliedWord;
	logic [31:0] targetPos;
	int modelKind;
	int modelLeft;
	logic [31:0] modelKnock;
	logic [31:0] modelMove;
	logic [15:0] lfsrState;
	int errorCount;

	attackCoprocessor u_dut (
		.clock(clock),
		.arstN(arstN),
		.char1Pos(char1Pos),
		.char1Size(char1Size),
		.char2Pos(char2Pos),
		.char2Size(char2Size),
		.controls(controls),
		.attack(attack),
		.knockback(knockback),
		.movement(movement)
	);

	always #10 clock = ~clock;

	initial begin
		#(cycleBudget * 20 + 2000);
		$display("Timeout: the tests did not finish within their cycle budget");
		$display("Done: errors found");
		$fatal(1);
	end

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			errorCount++;
			$display("ERROR at %0t: %s is %h, expected %h", $time, what, actual, expected);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	function automatic logic [31:0] makeWord(logic facing, logic [3:0] smash, logic b, logic a,
			logic [2:0] sx, logic [2:0] sy);
		logic [31:0] w;
		w = '0;
		w[26] = facing;
		w[23:20] = smash;
		w[17] = b;
		w[16] = a;
		w[15:13] = sx;
		w[7:5] = sy;
		return w;
	endfunction

	// Kind codes follow the attack list order with 0 for idle
	function automatic logic [31:0] wordFor(int kind);
		case (kind)
			1: return makeWord(0, 4'b1000, 0, 0, 3, 3);
			2: return makeWord(0, 4'b0100, 0, 0, 3, 3);
			3: return makeWord(0, 4'b0010, 0, 0, 3, 3);
			4: return makeWord(0, 4'b0001, 0, 0, 3, 3);
			5: return makeWord(0, 4'b0000, 0, 1, 3, 3);
			6: return makeWord(1, 4'b0000, 0, 1, 3, 3);
			7: return makeWord(0, 4'b0000, 1, 0, 3, 3);
			8: return makeWord(1, 4'b0000, 1, 0, 3, 3);
			9: return makeWord(0, 4'b0000, 1, 0, 0, 3);
			10: return makeWord(0, 4'b0000, 1, 0, 7, 3);
			11: return makeWord(0, 4'b0000, 1, 0, 3, 7);
			default: return makeWord(0, 4'b0000, 1, 0, 3, 0);
		endcase
	endfunction

	function automatic int decodeKind(logic [31:0] w);
		if (w[23]) return 1;
		if (w[22]) return 2;
		if (w[21]) return 3;
		if (w[20]) return 4;
		if (w[16]) return w[26] ? kindJabRight : kindJabLeft;
		if (!w[17]) return 0;
		if (w[15:13] == 3'b000) return 9;
		if (w[15:13] == 3'b111) return 10;
		if (w[7:5] == 3'b111) return 11;
		if (w[7:5] == 3'b000) return 12;
		return w[26] ? 8 : 7;
	endfunction

	function automatic logic hitExpected(int kind);
		logic [15:0] halfW;
		logic [15:0] halfH;
		logic [15:0] boxX;
		logic [15:0] boxY;
		logic [15:0] boxEndX;
		logic [15:0] boxEndY;
		logic [15:0] targetEndX;
		logic [15:0] targetEndY;
		halfW = char1Size[31:16] >> 1;
		halfH = char1Size[15:0] >> 1;
		case (kind)
			1, 5, 7, 9: begin
				boxX = char1Pos[31:16] - halfW;
				boxY = char1Pos[15:0] + (halfH >> 1);
			end
			2, 6, 8, 10: begin
				boxX = char1Pos[31:16] + char1Size[31:16];
				boxY = char1Pos[15:0] + (halfH >> 1);
			end
			3, 11: begin
				boxX = char1Pos[31:16] + (halfW >> 1);
				boxY = char1Pos[15:0] + char1Size[15:0];
			end
			default: begin
				boxX = char1Pos[31:16] + (halfW >> 1);
				boxY = char1Pos[15:0] - (halfH >> 1);
			end
		endcase
		boxEndX = boxX + halfW;
		boxEndY = boxY + halfH;
		targetEndX = char2Pos[31:16] + char2Size[31:16];
		targetEndY = char2Pos[15:0] + char2Size[15:0];
		return (kind != 0) && (boxX < targetEndX) && (char2Pos[31:16] < boxEndX) &&
			(boxY < targetEndY) && (char2Pos[15:0] < boxEndY);
	endfunction

	// Bit 0 is hit, bits 1 to 10 the kind flags in output order and bit 11 active
	function automatic logic [31:0] expectStatus(int kind, logic hit);
		logic [31:0] s;
		s = '0;
		if (kind != 0) begin
			s[0] = hit;
			s[11] = 1'b1;
			case (kind)
				1: s[3] = 1'b1;
				2: s[4] = 1'b1;
				3: s[1] = 1'b1;
				4: s[2] = 1'b1;
				5, 6: s[5] = 1'b1;
				7, 8: s[10] = 1'b1;
				9: s[8] = 1'b1;
				10: s[9] = 1'b1;
				11: s[6] = 1'b1;
				default: s[7] = 1'b1;
			endcase
		end
		return s;
	endfunction

	task automatic advanceModel(input logic [31:0] word);
		int req;
		case (modelKind)
			1: modelKnock = 32'hF7FE_00E0;
			2: modelKnock = 32'h0800_00E0;
			3: modelKnock = 32'h0000_0800;
			4: modelKnock = 32'h0000_F7FE;
			5: modelKnock = 32'hFBFE_0080;
			6: modelKnock = 32'h0400_0080;
			default: modelKnock = modelKnock;
		endcase
		if (modelKind == kindSpecialUp) modelMove = 32'h0000_0010;
		req = decodeKind(word);
		if (modelKind != 0) begin
			modelLeft--;
			if (modelLeft == 0) modelKind = 0;
		end else if (req != 0) begin
			modelKind = req;
			modelLeft = (req == kindJabLeft || req == kindJabRight) ? 8 : 16;
		end
	endtask

	// Model follows each edge and the outputs are checked at the falling edge
	task automatic stepCycle(input logic [31:0] word);
		@(posedge clock);
		advanceModel(appliedWord);
		#2;
		controls = word;
		appliedWord = word;
		char2Pos = targetPos;
		@(negedge clock);
		check(attack, expectStatus(modelKind, hitExpected(modelKind)), "attack status");
		check(knockback, modelKnock, "knockback");
		check(movement, modelMove, "movement");
	endtask

	task automatic runKind(input logic [31:0] word, input logic [31:0] hold);
		stepCycle(word);
		do begin
			stepCycle(hold);
		end while (attack.active);
	endtask

	task automatic placeTarget(input logic [15:0] x, input logic [15:0] y);
		targetPos = {x, y};
	endtask

	function automatic logic [15:0] lfsrStep(logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic takeBits(input int count, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrStep(lfsrState);
			bits = {bits[30:0], lfsrState[0]};
		end
	endtask

	task automatic idleAfterReset();
		repeat (6) stepCycle('0);
	endtask

	task automatic runEachKind();
		placeTarget(16'd3000, 16'd3000);
		for (int k = 1; k <= 12; k++) runKind(wordFor(k), '0);
	endtask

	task automatic lockoutAndPriority();
		runKind(wordFor(3), wordFor(kindJabLeft));
		stepCycle(wordFor(kindJabLeft));
		check(attack.jab, 1'b1, "held jab after idle cycle");
		do begin
			stepCycle('0);
		end while (attack.active);
		// Several requests at once
		runKind(makeWord(1, 4'b0101, 1, 1, 0, 7), '0);
		runKind(makeWord(0, 4'b0011, 1, 1, 3, 3), '0);
		runKind(makeWord(1, 4'b0000, 1, 1, 0, 0), '0);
		runKind(makeWord(0, 4'b0000, 1, 0, 0, 7), '0);
		runKind(makeWord(0, 4'b0000, 1, 0, 7, 0), '0);
		runKind(makeWord(1, 4'b0000, 1, 0, 2, 7), '0);
	endtask

	// Character 1 sits at (1000, 1000) with size 64 and the target is 8 wide
	// The last spot only touches the right box
	task automatic hitboxOverlaps();
		int spotX [5] = '{975, 1070, 1020, 1020, 1096};
		int spotY [5] = '{1020, 1020, 1070, 990, 1020};
		for (int p = 0; p < 5; p++) begin
			placeTarget(spotX[p], spotY[p]);
			for (int k = 1; k <= 12; k++) runKind(wordFor(k), '0);
		end
	endtask

	task automatic knockbackAndMovement();
		placeTarget(16'd3000, 16'd3000);
		runKind(wordFor(kindJabLeft), '0);
		check(knockback, 32'hFBFE_0080, "jab left knockback");
		runKind(wordFor(8), '0);
		runKind(wordFor(9), '0);
		check(knockback, 32'hFBFE_0080, "knockback held through specials");
		runKind(wordFor(kindSpecialUp), '0);
		check(movement, 32'h0000_0010, "movement after up special");
		stepCycle(wordFor(kindJabRight));
		stepCycle('0);
		stepCycle('0);
		check(knockback, 32'h0400_0080, "jab right knockback");
		do begin
			stepCycle('0);
		end while (attack.active);
	endtask

	task automatic randomWords();
		logic [31:0] word;
		logic [31:0] bias;
		for (int i = 0; i < 40; i++) begin
			takeBits(32, word);
			takeBits(2, bias);
			// Smash bits would otherwise win most words
			if (bias != 0) word[23:20] = 4'b0000;
			runKind(word, word);
		end
		// The last word is still held in the idle cycle
		stepCycle('0);
		while (attack.active) begin
			stepCycle('0);
		end
	endtask

	initial begin
		clock = 1'b0;
		arstN = 1'b0;
		controls = '0;
		char1Pos = {16'd1000, 16'd1000};
		char1Size = {16'd64, 16'd64};
		char2Size = {16'd8, 16'd8};
		targetPos = {16'd3000, 16'd3000};
		char2Pos = targetPos;
		appliedWord = '0;
		modelKind = 0;
		modelLeft = 0;
		modelKnock = '0;
		modelMove = '0;
		lfsrState = 16'd75;
		errorCount = 0;
		repeat (4) @(posedge clock);
		#2;
		arstN = 1'b1;
		idleAfterReset();
		runEachKind();
		lockoutAndPriority();
		hitboxOverlaps();
		knockbackAndMovement();
		randomWords();
		if (errorCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: project.f
source/fightPkg.sv
source/inputDecoder.sv
source/attackControl.sv
source/hitboxGenerator.sv
source/boxOverlap.sv
source/attackEffects.sv
source/attackCoprocessor.sv
tests/attackCoprocessorTb.sv

// File: Bender.yml
package:
  name: attackCoprocessor

sources:
  - source/fightPkg.sv
  - source/inputDecoder.sv
  - source/attackControl.sv
  - source/hitboxGenerator.sv
  - source/boxOverlap.sv
  - source/attackEffects.sv
  - source/attackCoprocessor.sv
  - target: test
    files:
      - tests/attackCoprocessorTb.sv
